// ==== sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// geometry
`define SDRAM_AW      22    // host word address width
`define SDRAM_ROW_W   13    // also the width of the A pins
`define SDRAM_COL_W   9
`define SDRAM_BANKS   4
`define SDRAM_BA_W    2
`define SDRAM_DW      16    // dq width

// timing, all in clk cycles
`define SDRAM_TRCD    2     // ACTIVE to READ/WRITE
`define SDRAM_TRP     2     // PRECHARGE to ACTIVE
`define SDRAM_TRRD    2     // ACTIVE to ACTIVE, other bank
`define SDRAM_CL      2     // cas latency

// one line = one burst
`define SDRAM_BURST   4

`endif

// ==== sdram_pkg.sv ====
`default_nettype none
`include "sdram_macros.svh"

package sdram_pkg;
    typedef logic [`SDRAM_AW-1:0]                addr_t;   // {bank, row, col}
    typedef logic [`SDRAM_ROW_W-1:0]             row_t;
    typedef logic [`SDRAM_COL_W-1:0]             col_t;
    typedef logic [`SDRAM_BA_W-1:0]              bank_t;
    typedef logic [`SDRAM_DW-1:0]                word_t;
    typedef logic [`SDRAM_BURST*`SDRAM_DW-1:0]   line_t;   // first word in the low bits
    typedef logic [`SDRAM_ROW_W-1:0]             pin_a_t;

    // levels of /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1000   // chip not selected
    } sdram_cmd_t;

    typedef enum logic [2:0] {
        IDLE,       // row open or closed, waiting for a request
        PRE_ACT,    // precharge issued, waiting tRP
        PRE_RD,     // activate issued, waiting tRCD
        READ,       // read/write on the pins
        BURST       // data window of the access
    } bank_st_t;

    // host address only has room for 11 row bits, upper row bits stay zero
    localparam int ROW_AW = `SDRAM_AW - `SDRAM_BA_W - `SDRAM_COL_W;

    function automatic bank_t addr_bank(addr_t a);
        return a[`SDRAM_AW-1 -: `SDRAM_BA_W];
    endfunction

    function automatic row_t addr_row(addr_t a);
        return row_t'(a[`SDRAM_COL_W +: ROW_AW]);
    endfunction

    function automatic col_t addr_col(addr_t a);
        return a[`SDRAM_COL_W-1:0];
    endfunction
endpackage

`default_nettype wire

// ==== sdram_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// request stage to one bank
interface sdram_req_if
    import sdram_pkg::*;
();
    logic rd;       // line read
    logic wr;       // single word write
    row_t row;
    col_t col;
    logic ack;      // pulses when the bank issues READ/WRITE

    modport master (output rd, wr, row, col, input ack);
    modport slave  (input rd, wr, row, col, output ack);
endinterface

// one bank to the command stage
interface sdram_bank_if
    import sdram_pkg::*;
();
    logic       br;         // bus request
    sdram_cmd_t cmd;        // only meaningful with bg
    pin_a_t     a;
    logic       wr_busy;    // write granted, drive dq
    logic       dbusy;      // read data window
    logic       dqm_busy;   // masked write beats
    logic       act;        // tRRD window after ACTIVE

    logic       bg;         // bus grant
    logic       all_dbusy;
    logic       all_dqm;
    logic       all_act;

    modport bank (
        output br, cmd, a, wr_busy, dbusy, dqm_busy, act,
        input  bg, all_dbusy, all_dqm, all_act
    );
    modport arbiter (
        input  br, cmd, a, wr_busy, dbusy, dqm_busy, act,
        output bg, all_dbusy, all_dqm, all_act
    );
endinterface

`default_nettype wire

// ==== sdram_req_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_req_stage
    import sdram_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire          rd,
    input wire          wr,
    input wire addr_t   addr,
    sdram_req_if.master req [0:`SDRAM_BANKS-1]
);
    logic                    busy;      // a request is held for a bank
    logic                    rd_q;
    logic                    wr_q;
    bank_t                   bank_q;
    row_t                    row_q;
    col_t                    col_q;
    logic [`SDRAM_BANKS-1:0] ack_v;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (busy) begin
            if (|ack_v) busy <= 1'b0;    // free again the cycle after ack
        end else if (rd || wr) begin
            busy <= 1'b1;
            rd_q <= rd;
            wr_q <= wr && !rd;           // read wins if both show up
        end
    end

    // address fields, held while busy
    always_ff @(posedge clk) begin
        if (!busy) begin
            bank_q <= addr_bank(addr);
            row_q  <= addr_row(addr);
            col_q  <= addr_col(addr);
        end
    end

    for (genvar i = 0; i < `SDRAM_BANKS; i++) begin : g_steer
        assign req[i].rd  = busy && rd_q && bank_q == bank_t'(i);  // only the target bank
        assign req[i].wr  = busy && wr_q && bank_q == bank_t'(i);
        assign req[i].row = row_q;
        assign req[i].col = col_q;
        assign ack_v[i]   = req[i].ack;
    end
endmodule

`default_nettype wire

// ==== sdram_bank.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_bank
    import sdram_pkg::*;
(
    input wire          clk,
    input wire          rst,
    sdram_req_if.slave  req,
    sdram_bank_if.bank  bus
);
    // wait counter loads, the counter sits at zero on the cycle the next command may go
    localparam logic [2:0] TRP_LD   = 3'(`SDRAM_TRP - 1);
    localparam logic [2:0] TRCD_LD  = 3'(`SDRAM_TRCD - 1);
    localparam logic [1:0] TRRD_LD  = 2'(`SDRAM_TRRD - 1);
    // BURST state length, READ state already covers one cycle
    localparam logic [2:0] RD_WIN   = 3'(`SDRAM_CL + `SDRAM_BURST - 3);
    localparam logic [2:0] WR_WIN   = 3'(`SDRAM_BURST - 3);

    bank_st_t   st;
    logic [2:0] cnt;            // tRP / tRCD / data window
    logic [1:0] act_cnt;        // tRRD after our ACTIVE
    row_t       open_row;
    logic       actd;           // a row is open in this bank
    logic       rd_q;           // last access was a read
    logic       want;
    logic       hit;
    logic       do_prech;
    logic       do_act;
    logic       do_rw;
    logic       legal;

    assign want = req.rd | req.wr;
    assign hit  = actd && open_row == req.row;

    // what this bank would put on the bus now
    always_comb begin
        do_prech = 1'b0;
        do_act   = 1'b0;
        do_rw    = 1'b0;
        case (st)
            IDLE: begin
                if (want) begin
                    if (hit)
                        do_rw = 1'b1;        // row hit goes straight out
                    else if (actd)
                        do_prech = 1'b1;     // wrong row open
                    else
                        do_act = 1'b1;       // bank closed
                end
            end
            PRE_ACT: do_act = cnt == 3'd0;
            PRE_RD:  do_rw  = cnt == 3'd0;
            default: ;
        endcase
    end

    // no point asking while the shared flags would block us
    assign legal = !bus.all_dqm
                && !(do_rw && bus.all_dbusy)
                && !(do_act && bus.all_act);
    assign bus.br = (do_prech | do_act | do_rw) && legal;

    always_comb begin
        bus.cmd = CMD_NOP;
        bus.a   = '0;                            // A10 low, this bank only
        if (do_prech) begin
            bus.cmd = CMD_PRECHARGE;
        end else if (do_act) begin
            bus.cmd = CMD_ACTIVE;
            bus.a   = req.row;
        end else if (do_rw) begin
            bus.cmd = req.rd ? CMD_READ : CMD_WRITE;
            bus.a   = pin_a_t'(req.col);         // no auto precharge
        end
    end

    assign req.ack      = bus.bg && do_rw;
    assign bus.wr_busy  = bus.bg && do_rw && req.wr;
    assign bus.dbusy    = rd_q && (st == READ || st == BURST);   // read data window
    assign bus.dqm_busy = !rd_q && (st == READ || st == BURST);  // masked write beats
    assign bus.act      = act_cnt != 2'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= IDLE;
            cnt     <= '0;
            act_cnt <= '0;
            actd    <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            if (act_cnt != 2'd0) act_cnt <= act_cnt - 2'd1;
            case (st)
                IDLE, PRE_ACT, PRE_RD: begin
                    if (cnt != 3'd0) cnt <= cnt - 3'd1;
                    if (bus.bg) begin            // denied: stay and retry
                        if (do_prech) begin
                            st   <= PRE_ACT;
                            cnt  <= TRP_LD;
                            actd <= 1'b0;
                        end
                        if (do_act) begin
                            st      <= PRE_RD;
                            cnt     <= TRCD_LD;
                            actd    <= 1'b1;
                            act_cnt <= TRRD_LD;
                        end
                        if (do_rw) begin
                            st   <= READ;
                            rd_q <= req.rd;
                        end
                    end
                end
                READ: begin
                    st  <= BURST;
                    cnt <= rd_q ? RD_WIN : WR_WIN;
                end
                BURST: begin
                    if (cnt == 3'd0)
                        st <= IDLE;
                    else
                        cnt <= cnt - 3'd1;
                end
                default: st <= IDLE;
            endcase
        end
    end

    // open row, valid while actd
    always_ff @(posedge clk) begin
        if (bus.bg && do_act) open_row <= req.row;
    end

    // grant only while this bank asks, so no command goes out unasked
    a_cmd_needs_bg: assert property (@(posedge clk) disable iff (rst)
        bus.bg |-> bus.br);

    // tRCD from our ACTIVE to our READ/WRITE
    a_trcd: assert property (@(posedge clk) disable iff (rst)
        (bus.bg && bus.cmd == CMD_ACTIVE)
        |=> !(bus.bg && bus.cmd inside {CMD_READ, CMD_WRITE}) [*`SDRAM_TRCD-1]);
endmodule

`default_nettype wire

// ==== sdram_cmd_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_cmd_stage
    import sdram_pkg::*;
(
    input wire              clk,
    input wire              rst,
    sdram_bank_if.arbiter   bus [0:`SDRAM_BANKS-1],
    input wire word_t       din,
    output sdram_cmd_t      sdram_cmd,
    output pin_a_t          sdram_a,
    output bank_t           sdram_ba,
    output logic [1:0]      sdram_dqm,
    output word_t           sdram_dq_out,
    output logic            sdram_dq_oe,
    output logic            rd_issue        // READ granted this cycle
);
    localparam int NB = `SDRAM_BANKS;

    logic [NB-1:0] legal_v;
    logic [NB-1:0] bg_v;
    logic [NB-1:0] dbusy_v;
    logic [NB-1:0] dqm_v;
    logic [NB-1:0] act_v;
    logic [NB-1:0] wr_v;
    logic [3:0]    cmd_g [NB];      // zero unless granted
    pin_a_t        a_g [NB];
    logic          all_dbusy;
    logic          all_dqm;
    logic          all_act;
    logic [3:0]    cmd_or;
    pin_a_t        a_or;
    bank_t         ba_enc;
    logic          any_bg;
    logic          any_wr;
    logic [2:0]    dqm_cnt;         // read beats that still need DQM low

    for (genvar i = 0; i < NB; i++) begin : g_port
        assign dbusy_v[i] = bus[i].dbusy;
        assign dqm_v[i]   = bus[i].dqm_busy;
        assign act_v[i]   = bus[i].act;
        assign wr_v[i]    = bus[i].wr_busy;
        assign legal_v[i] = bus[i].br && !all_dqm
                         && !(bus[i].cmd inside {CMD_READ, CMD_WRITE} && all_dbusy)
                         && !(bus[i].cmd == CMD_ACTIVE && all_act);
        assign cmd_g[i]   = bg_v[i] ? bus[i].cmd : 4'b0000;
        assign a_g[i]     = bg_v[i] ? bus[i].a : '0;
        assign bus[i].bg        = bg_v[i];
        assign bus[i].all_dbusy = all_dbusy;
        assign bus[i].all_dqm   = all_dqm;
        assign bus[i].all_act   = all_act;
    end

    assign all_dbusy = |dbusy_v;
    assign all_dqm   = |dqm_v;
    assign all_act   = |act_v;
    assign bg_v      = legal_v & (~legal_v + NB'(1));  // lowest legal requester
    assign any_bg    = |bg_v;
    assign any_wr    = |wr_v;

    always_comb begin
        cmd_or = '0;
        a_or   = '0;
        ba_enc = '0;
        for (int i = 0; i < NB; i++) begin
            cmd_or = cmd_or | cmd_g[i];
            a_or   = a_or | a_g[i];
            if (bg_v[i]) ba_enc = bank_t'(i);
        end
    end

    assign rd_issue = any_bg && sdram_cmd_t'(cmd_or) == CMD_READ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_cmd   <= CMD_NOP;
            sdram_a     <= '0;
            sdram_ba    <= '0;
            sdram_dqm   <= 2'b11;
            sdram_dq_oe <= 1'b0;
            dqm_cnt     <= '0;
        end else begin
            sdram_cmd   <= any_bg ? sdram_cmd_t'(cmd_or) : CMD_NOP;
            sdram_a     <= a_or;
            sdram_ba    <= ba_enc;
            sdram_dq_oe <= any_wr;                       // write data only in the WRITE cycle
            if (rd_issue)
                dqm_cnt <= 3'(`SDRAM_BURST - 1);
            else if (dqm_cnt != 3'd0)
                dqm_cnt <= dqm_cnt - 3'd1;
            // low for a write beat or a read burst, otherwise masked
            sdram_dqm <= (rd_issue || any_wr || dqm_cnt != 3'd0) ? 2'b00 : 2'b11;
        end
    end

    always_ff @(posedge clk) begin
        if (any_wr) sdram_dq_out <= din;                 // host holds din until ack
    end

    // one granted bank, one real command on the merged bus
    a_one_bg: assert property (@(posedge clk) disable iff (rst)
        any_bg |-> sdram_cmd_t'(cmd_or) inside {CMD_PRECHARGE, CMD_ACTIVE,
                                                CMD_READ, CMD_WRITE});
endmodule

`default_nettype wire

// ==== sdram_rd_capture.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_rd_capture
    import sdram_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire          rd_issue,       // READ grant, pins follow one cycle later
    input wire word_t   sdram_dq_in,
    output line_t       dout,
    output logic        dok
);
    // grant, pin cycle, CL, burst beats
    localparam int DEPTH = `SDRAM_CL + 1 + `SDRAM_BURST;

    logic [DEPTH-1:0] tag;      // tag[k] set k+1 cycles after the grant
    logic             beat;     // dq carries a read word now

    assign beat = |tag[`SDRAM_CL +: `SDRAM_BURST];
    assign dok  = tag[DEPTH-1];  // cycle after the last word

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tag <= '0;
        else
            tag <= {tag[DEPTH-2:0], rd_issue};
    end

    // words enter at the top, so the first one ends in the low bits
    always_ff @(posedge clk) begin
        if (beat) dout <= {sdram_dq_in, dout[$bits(line_t)-1:$bits(word_t)]};
    end
endmodule

`default_nettype wire

// ==== sdram_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_ctrl
    import sdram_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire addr_t   addr,
    input wire          rd,
    input wire          wr,
    input wire word_t   din,
    output logic        ack,
    output line_t       dout,
    output logic        dok,
    output sdram_cmd_t  sdram_cmd,
    output pin_a_t      sdram_a,
    output bank_t       sdram_ba,
    output logic [1:0]  sdram_dqm,
    output word_t       sdram_dq_out,
    output logic        sdram_dq_oe,
    input wire word_t   sdram_dq_in
);
    sdram_req_if  req_if  [0:`SDRAM_BANKS-1] ();
    sdram_bank_if bank_if [0:`SDRAM_BANKS-1] ();

    logic [`SDRAM_BANKS-1:0] ack_v;
    logic                    rd_issue;

    sdram_req_stage req_stage_inst (
        .clk  (clk),
        .rst  (rst),
        .rd   (rd),
        .wr   (wr),
        .addr (addr),
        .req  (req_if)
    );

    for (genvar i = 0; i < `SDRAM_BANKS; i++) begin : g_bank
        sdram_bank bank_inst (
            .clk (clk),
            .rst (rst),
            .req (req_if[i]),
            .bus (bank_if[i])
        );
        assign ack_v[i] = req_if[i].ack;
    end

    assign ack = |ack_v;    // at most one bank acks per cycle

    sdram_cmd_stage cmd_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .bus          (bank_if),
        .din          (din),
        .sdram_cmd    (sdram_cmd),
        .sdram_a      (sdram_a),
        .sdram_ba     (sdram_ba),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq_out (sdram_dq_out),
        .sdram_dq_oe  (sdram_dq_oe),
        .rd_issue     (rd_issue)
    );

    sdram_rd_capture rd_capture_inst (
        .clk         (clk),
        .rst         (rst),
        .rd_issue    (rd_issue),
        .sdram_dq_in (sdram_dq_in),
        .dout        (dout),
        .dok         (dok)
    );
endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);  // reset held for 8 cycles
        rst <= 1'b0;
    end
endmodule

`default_nettype wire

// ==== sdram_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_model
    import sdram_pkg::*;
(
    input wire             clk,
    input wire             rst,
    input wire sdram_cmd_t cmd,
    input wire pin_a_t     a,
    input wire bank_t      ba,
    input wire [1:0]       dqm,
    input wire word_t      dq_out,
    input wire             dq_oe,
    output word_t          dq_in,
    output logic           viol      // protocol error seen
);
    word_t mem [bit [23:0]];          // sparse, key {bank, row, col}
    int    cyc;
    int    t_act [`SDRAM_BANKS];
    int    t_pre [`SDRAM_BANKS];
    int    t_act_any;
    bit    open_b [`SDRAM_BANKS];
    row_t  orow [`SDRAM_BANKS];
    word_t rd_sched [8];              // slot k drives dq_in k+1 edges later
    int    wr_beat;                   // remaining masked write beats
    bank_t wr_ba;
    col_t  wr_col;
    int    wr_idx;

    // untouched words still hold a value tied to their whole address
    function automatic word_t fetch(bit [23:0] key);
        if (mem.exists(key)) return mem[key];
        return word_t'(key ^ (key >> 10) ^ 24'h00a5c3);
    endfunction

    function automatic col_t beat_col(col_t c, int k);
        return {c[8:2], 2'(c[1:0] + k)};   // sequential burst, wraps in 4
    endfunction

    task automatic flag(string msg);
        $display("SDRAM model error at %0t ns: %s", $time, msg);
        viol <= 1'b1;
    endtask

    initial begin
        viol      = 1'b0;
        dq_in     = '0;
        cyc       = 0;
        t_act_any = -100;
        wr_beat   = 0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            t_act[i]  = -100;
            t_pre[i]  = -100;
            open_b[i] = 1'b0;
        end
        for (int k = 0; k < 8; k++) rd_sched[k] = '0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cyc++;
            dq_in <= rd_sched[0];
            for (int k = 0; k < 7; k++) rd_sched[k] = rd_sched[k+1];
            rd_sched[7] = '0;
            if (wr_beat > 0) begin       // later write beats, kept only if unmasked
                if (dqm == 2'b00)
                    mem[{wr_ba, orow[wr_ba], beat_col(wr_col, wr_idx)}] = dq_out;
                wr_idx++;
                wr_beat--;
            end
            case (cmd)
                CMD_NOP, CMD_INHIBIT: ;
                CMD_ACTIVE: begin
                    if (open_b[ba]) flag("ACTIVE to a bank that already has an open row");
                    if (cyc - t_pre[ba] < `SDRAM_TRP) flag("tRP violated");
                    if (cyc - t_act_any < `SDRAM_TRRD) flag("tRRD violated");
                    open_b[ba] = 1'b1;
                    orow[ba]   = row_t'(a);
                    t_act[ba]  = cyc;
                    t_act_any  = cyc;
                end
                CMD_PRECHARGE: begin
                    for (int i = 0; i < `SDRAM_BANKS; i++) begin
                        if (a[10] || bank_t'(i) == ba) begin  // A10 means all banks
                            open_b[i] = 1'b0;
                            t_pre[i]  = cyc;
                        end
                    end
                end
                CMD_READ, CMD_WRITE: begin
                    if (!open_b[ba]) flag("read or write to a closed row");
                    if (cyc - t_act[ba] < `SDRAM_TRCD) flag("tRCD violated");
                    if (cmd == CMD_READ) begin
                        for (int k = 0; k < `SDRAM_BURST; k++)
                            rd_sched[k] = fetch({ba, orow[ba], beat_col(col_t'(a), k)});
                    end else begin
                        if (dqm == 2'b00) begin
                            if (!dq_oe) flag("write data not driven in the WRITE cycle");
                            mem[{ba, orow[ba], col_t'(a)}] = dq_out;
                        end
                        wr_beat = `SDRAM_BURST - 1;
                        wr_ba   = ba;
                        wr_col  = col_t'(a);
                        wr_idx  = 1;
                    end
                end
                default: flag("two commands at once or an undefined command on the pins");
            endcase
        end
    end
endmodule

`default_nettype wire

// ==== sdram_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sdram_macros.svh"

module sdram_ctrl_tb
    import sdram_pkg::*;
();
    logic       clk;
    logic       rst;
    addr_t      addr;
    logic       rd;
    logic       wr;
    word_t      din;
    logic       ack;
    line_t      dout;
    logic       dok;
    sdram_cmd_t sdram_cmd;
    pin_a_t     sdram_a;
    bank_t      sdram_ba;
    logic [1:0] sdram_dqm;
    word_t      sdram_dq_out;
    logic       sdram_dq_oe;
    word_t      sdram_dq_in;
    logic       viol;

    logic [31:0] lcg_state = 32'hc1ca_9486;
    word_t       ref_mem [addr_t];      // what the host wrote
    bit          logging = 1'b0;
    sdram_cmd_t  log_cmd [$];
    pin_a_t      log_a [$];
    bank_t       log_ba [$];
    logic [1:0]  log_dqm [$];
    line_t       exp_q [$];

    tb_clk_gen clk_gen_inst (.clk(clk), .rst(rst));

    sdram_ctrl sdram_ctrl_inst (
        .clk(clk), .rst(rst), .addr(addr), .rd(rd), .wr(wr), .din(din),
        .ack(ack), .dout(dout), .dok(dok),
        .sdram_cmd(sdram_cmd), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
        .sdram_dqm(sdram_dqm), .sdram_dq_out(sdram_dq_out),
        .sdram_dq_oe(sdram_dq_oe), .sdram_dq_in(sdram_dq_in)
    );

    sdram_model sdram_model_inst (
        .clk(clk), .rst(rst), .cmd(sdram_cmd), .a(sdram_a), .ba(sdram_ba),
        .dqm(sdram_dqm), .dq_out(sdram_dq_out), .dq_oe(sdram_dq_oe),
        .dq_in(sdram_dq_in), .viol(viol)
    );

    // pin trace, sampled mid-cycle
    always @(negedge clk) begin
        if (logging) begin
            log_cmd.push_back(sdram_cmd);
            log_a.push_back(sdram_a);
            log_ba.push_back(sdram_ba);
            log_dqm.push_back(sdram_dqm);
        end
    end

    always @(posedge viol) begin
        $display("TEST FAILED");
        $fatal(1, "the SDRAM model saw a protocol violation");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t make_addr(bank_t b, logic [10:0] r, col_t c);
        return {b, r, c};
    endfunction

    function automatic line_t expected_line(addr_t a);
        line_t e;
        for (int k = 0; k < `SDRAM_BURST; k++) e[k*16 +: 16] = ref_mem[a + addr_t'(k)];
        return e;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_run("wrong value");
        end
    endtask

    task automatic check_line(line_t got, line_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_run("wrong read line");
        end
    endtask

    task automatic check_cmd(sdram_cmd_t got, sdram_cmd_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %s expected %s", $time, what,
                     got.name(), exp.name());
            stop_run("wrong command");
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            stop_run("wrong flag");
        end
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 40) stop_run("timeout: no ack from the controller");
        end while (!ack);
    endtask

    task automatic wait_dok();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 100) stop_run("timeout: no dok from the controller");
        end while (!dok);
    endtask

    task automatic write_word(addr_t a, word_t d);
        @(posedge clk);
        addr <= a;
        din  <= d;
        wr   <= 1'b1;
        wait_ack();
        @(posedge clk);
        wr <= 1'b0;
        ref_mem[a] = d;
    endtask

    task automatic write_line(addr_t a);
        for (int k = 0; k < `SDRAM_BURST; k++) write_word(a + addr_t'(k), word_t'(lcg_next()));
    endtask

    // cycles counts from the cycle rd rises to the cycle dok is high
    task automatic read_line(addr_t a, output line_t got, output int cycles);
        time t0;
        @(posedge clk);
        t0 = $time;
        addr <= a;
        rd   <= 1'b1;
        wait_ack();
        @(posedge clk);
        rd <= 1'b0;
        wait_dok();
        got    = dout;
        cycles = int'(($time - t0 - 4) / 8);
    endtask

    task automatic start_log();
        log_cmd.delete();
        log_a.delete();
        log_ba.delete();
        log_dqm.delete();
        logging = 1'b1;
    endtask

    task automatic test_reset_state();
        repeat (6) begin
            @(negedge clk);
            check_cmd(sdram_cmd, CMD_NOP, "idle command");
            check_word(word_t'(sdram_dqm), 16'h3, "idle dqm");
            check_bit(sdram_dq_oe, 1'b0, "idle dq_oe");
            check_bit(ack, 1'b0, "idle ack");
            check_bit(dok, 1'b0, "idle dok");
        end
    endtask

    task automatic test_write_read(addr_t a);
        line_t got;
        int    cyc;
        write_line(a);
        read_line(a, got, cyc);
        check_line(got, expected_line(a), "write then read");
    endtask

    task automatic test_row_hit(addr_t a);
        line_t got;
        int    cyc;
        start_log();
        read_line(a, got, cyc);
        logging = 1'b0;
        check_line(got, expected_line(a), "row hit data");
        check_word(word_t'(cyc), 16'd8, "row hit latency");
        foreach (log_cmd[i])
            if (log_cmd[i] inside {CMD_PRECHARGE, CMD_ACTIVE})
                stop_run("row hit issued PRECHARGE or ACTIVE");
    endtask

    task automatic test_row_miss(addr_t a, addr_t other);
        line_t      got;
        int         cyc;
        sdram_cmd_t seq [$];
        pin_a_t     seq_a [$];
        bank_t      seq_ba [$];
        write_line(other);                  // opens another row in the same bank
        repeat (4) @(posedge clk);          // last WRITE off the pins
        start_log();
        read_line(a, got, cyc);
        logging = 1'b0;
        foreach (log_cmd[i]) begin
            if (log_cmd[i] != CMD_NOP) begin
                seq.push_back(log_cmd[i]);
                seq_a.push_back(log_a[i]);
                seq_ba.push_back(log_ba[i]);
            end
        end
        if (seq.size() != 3) stop_run("row miss did not show three commands");
        check_cmd(seq[0], CMD_PRECHARGE, "row miss 1st");
        check_cmd(seq[1], CMD_ACTIVE, "row miss 2nd");
        check_word(word_t'(seq_a[1]), word_t'(a[`SDRAM_AW-3:`SDRAM_COL_W]), "activated row");
        check_cmd(seq[2], CMD_READ, "row miss 3rd");
        foreach (seq_ba[i])
            check_word(word_t'(seq_ba[i]), word_t'(a[`SDRAM_AW-1 -: 2]), "row miss bank");
        check_line(got, expected_line(a), "row miss data");
    endtask

    task automatic test_write_mask(addr_t a);
        line_t got;
        int    cyc;
        bit    seen;
        seen = 1'b0;
        write_line(a);
        repeat (4) @(posedge clk);          // earlier writes off the pins
        start_log();
        write_word(a + addr_t'(1), word_t'(lcg_next()));
        repeat (6) @(posedge clk);
        logging = 1'b0;
        foreach (log_cmd[i]) begin
            if (log_cmd[i] == CMD_WRITE) seen = 1'b1;
            check_word(word_t'(log_dqm[i]), (log_cmd[i] == CMD_WRITE) ? 16'h0 : 16'h3,
                       "dqm around write");
        end
        if (!seen) stop_run("single write never reached the pins");
        read_line(a, got, cyc);
        check_line(got, expected_line(a), "masked neighbours");
    endtask

    task automatic test_interleave(int n);
        addr_t as [$];
        for (int i = 0; i < n; i++) begin
            as.push_back(make_addr(bank_t'(i % 4), 11'(lcg_next()),
                                   {7'(lcg_next()), 2'b00}));
            write_line(as[i]);
        end
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    @(posedge clk);             // next request the cycle after ack
                    addr <= as[i];
                    rd   <= 1'b1;
                    wait_ack();
                    exp_q.push_back(expected_line(as[i]));
                end
                @(posedge clk);
                rd <= 1'b0;
            end
            begin
                for (int i = 0; i < n; i++) begin
                    wait_dok();
                    if (exp_q.size() == 0) stop_run("dok without an issued read");
                    check_line(dout, exp_q.pop_front(), "interleaved read");
                end
            end
        join
    endtask

    initial begin
        int n;
        addr = '0;
        rd   = 1'b0;
        wr   = 1'b0;
        din  = '0;
        n    = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 20) stop_run("timeout: reset never released");
        end
        test_reset_state();
        test_write_read(make_addr(2'd1, 11'h123, 9'h040));
        test_row_hit(make_addr(2'd1, 11'h123, 9'h040));
        test_row_miss(make_addr(2'd1, 11'h123, 9'h040), make_addr(2'd1, 11'h2a5, 9'h080));
        test_write_mask(make_addr(2'd3, 11'h055, 9'h100));
        test_interleave(12);
        repeat (10) @(posedge clk);
        if (viol) begin
            $display("TEST FAILED");
            $fatal(1, "the SDRAM model saw a protocol violation");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end
endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
sdram_pkg.sv
sdram_ifs.sv
sdram_req_stage.sv
sdram_bank.sv
sdram_cmd_stage.sv
sdram_rd_capture.sv
sdram_ctrl.sv
tb_clk_gen.sv
sdram_model.sv
sdram_ctrl_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +incdir+%,$(shell cat project.f)) sdram_macros.svh

.PHONY: compile run clean

compile: obj_dir/Vsdram_ctrl_tb

obj_dir/Vsdram_ctrl_tb: $(SRCS) project.f
	verilator --binary --timing --assert -f project.f --top-module sdram_ctrl_tb \
		-o Vsdram_ctrl_tb

run: compile
	./obj_dir/Vsdram_ctrl_tb

clean:
	rm -rf obj_dir
